//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = vmaTb
FLIST = kl10Vma.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

//--- kl10Vma.f
verilog/kl10WordPkg.sv
verilog/vmaCtlPkg.sv
verilog/vmaCounter.sv
verilog/vmaHistory.sv
verilog/vmaStatus.sv
verilog/vmaTop.sv
verification/vmaTb_assertions.sv
verification/vmaTb.sv

//--- verification/vmaTb.sv
`timescale 1ns/1ps
`default_nettype none

module vmaTb;

  localparam int RESET_CYCLES = 10;
  localparam int DECODE_RUNS  = 60;
  localparam int DIAG_RUNS    = 16;
  // Directed groups: load 4, count 4, section 9, history 3, flags 2
  localparam int TEST_CYCLES  = RESET_CYCLES + 4 + 4 + 9 + 3 + DECODE_RUNS + DIAG_RUNS + 2;
  localparam int CYCLE_LIMIT  = 2 * TEST_CYCLES;

  logic clk, rstN, condVmaMagic, vmaInc, vmaAdSel, vmaLoad, vmaCount, vmaxEn;
  logic loadPc, loadVmaHeld, condSelVma, datAoApr, loadPrevContext;
  logic vmaExtended, vmaFetch, pageRef, readOrWrite, readVma;
  logic acRef, match, localAcAddress, ebusDriving;
  kl10WordPkg::addrT edpAd, vma, pc, heldOrPc;
  kl10WordPkg::magicT magic;
  kl10WordPkg::wordT ebusData;
  vmaCtlPkg::sectionSelT vmaxSel;
  vmaCtlPkg::diagSelT diagSel;

  // Shadow registers
  kl10WordPkg::addrT sVma, sPc, sHeld, sBrk;
  kl10WordPkg::sectionT sPrev;
  int errors = 0;
  int cycles = 0;
  int seed = 32'hc89f6eb2;

  vmaTop dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: the run went past %0d cycles", CYCLE_LIMIT);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic clearStrobes();
    {condVmaMagic, vmaInc, vmaAdSel, vmaLoad, vmaCount, vmaxEn} = '0;
    {loadPc, loadVmaHeld, datAoApr, loadPrevContext} = '0;
    vmaxSel = vmaCtlPkg::SEC_KEEP;
  endtask

  task automatic loadVmaFromAd(kl10WordPkg::addrT addr, vmaCtlPkg::sectionSelT sel);
    edpAd = addr;
    vmaLoad = 1;
    vmaAdSel = 1;
    vmaxEn = 1;
    vmaxSel = sel;
  endtask

  task automatic modelClock();
    kl10WordPkg::offsetT off;
    kl10WordPkg::sectionT sec;
    off = sVma[17:0];
    sec = sVma[22:18];
    if (vmaLoad) begin
      if (vmaAdSel) off = edpAd[17:0];
      else if (condVmaMagic) off = 18'(magic) + 18'(vmaInc);
      else off = sPc[17:0] + 18'(vmaInc);
      if (vmaxEn && vmaxSel == 2'd1) sec = sPc[22:18];
      if (vmaxEn && vmaxSel == 2'd2) sec = sPrev;
      if (vmaxEn && vmaxSel == 2'd3) sec = edpAd[22:18];
    end else if (vmaCount) begin
      off = off + 18'd1;
    end
    if (loadPc) sPc = sVma;
    if (loadVmaHeld) sHeld = sVma;
    if (datAoApr) sBrk = edpAd;
    if (loadPrevContext) sPrev = edpAd[22:18];
    sVma = {sec, off};
  endtask

  task automatic checkVal(string name, string what, logic [35:0] exp, logic [35:0] act);
    if (exp !== act) begin
      errors++;
      $display("error %s %s expected %h actual %h", name, what, exp, act);
    end
  endtask

  task automatic checkAll(string name);
    logic localRef, acOff;
    logic [35:0] expEbus;
    localRef = !vmaExtended || vmaFetch || sVma[22:18] == 0;
    acOff = sVma[17:0] < 16;
    expEbus = 0;
    if (readVma) begin
      case (diagSel)
        3'd0: expEbus = 36'(sVma);
        3'd1: expEbus = 36'(sPc);
        3'd2: expEbus = 36'(sHeld);
        3'd3: expEbus = 36'(sBrk);
        3'd4: expEbus = {28'd0, sVma[22:18] == 0, sPc[22:18] == 0, sPrev == 0, sPrev};
        default: expEbus = 0;
      endcase
    end
    checkVal(name, "vma", 36'(sVma), 36'(vma));
    checkVal(name, "pc", 36'(sPc), 36'(pc));
    checkVal(name, "heldOrPc", 36'(condSelVma ? sHeld : sPc), 36'(heldOrPc));
    checkVal(name, "acRef", 36'(acOff && localRef && pageRef && readOrWrite), 36'(acRef));
    checkVal(name, "localAc", 36'(acOff && localRef && sVma[22:18] != 0), 36'(localAcAddress));
    checkVal(name, "match", 36'(sVma == sBrk), 36'(match));
    checkVal(name, "ebusData", expEbus, ebusData);
    checkVal(name, "ebusDriving", 36'(readVma), 36'(ebusDriving));
  endtask

  task automatic tick(string name);
    @(posedge clk);
    modelClock();
    @(negedge clk);
    checkAll(name);
    clearStrobes();
  endtask

  initial begin
    rstN = 1'b0;
    clearStrobes();
    {condSelVma, vmaExtended, vmaFetch, pageRef, readOrWrite, readVma} = '0;
    edpAd = '0;
    magic = '0;
    diagSel = '0;
    {sVma, sPc, sHeld, sBrk, sPrev} = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rstN = 1'b1;
    checkAll("reset");
    // Loading from the data path, the PC adder and the magic number
    loadVmaFromAd(23'h15_4321, vmaCtlPkg::SEC_AD);
    tick("loadAd");
    loadPc = 1;
    tick("loadPc");
    vmaLoad = 1;
    vmaInc = 1;
    tick("loadPcInc");
    vmaLoad = 1;
    condVmaMagic = 1;
    magic = 9'h1a5;
    vmaInc = 1;
    tick("loadMagic");
    // Counting with wrap and load priority
    loadVmaFromAd(23'h0b_ffff, vmaCtlPkg::SEC_AD);
    tick("loadTop");
    vmaCount = 1;
    tick("countWrap");
    vmaCount = 1;
    tick("count");
    vmaCount = 1;
    vmaLoad = 1;
    vmaAdSel = 1;
    tick("loadOverCount");
    // Section sources
    edpAd = 23'h1c_0000;
    loadPrevContext = 1;
    tick("prevLoad");
    for (int s = 0; s < 4; s++) begin
      loadVmaFromAd(23'($random(seed)), 2'(s));
      tick("sectionSel");
      loadVmaFromAd(23'($random(seed)), 2'(s));
      vmaxEn = 0;
      tick("sectionKeep");
    end
    // History registers, the VMA steps on after the held copy
    loadVmaHeld = 1;
    vmaCount = 1;
    tick("heldLoad");
    condSelVma = 1;
    edpAd = 23'($random(seed));
    datAoApr = 1;
    tick("brkLoad");
    edpAd = sVma;
    datAoApr = 1;
    condSelVma = 0;
    tick("brkMatch");
    // Decode over random addresses
    for (int i = 0; i < DECODE_RUNS; i++) begin
      edpAd = 23'($random(seed));
      if (i % 2 == 0) edpAd[17:0] = 18'($random(seed) & 15);
      if (i % 5 == 0) edpAd[22:18] = 0;
      {vmaExtended, vmaFetch, pageRef, readOrWrite} = 4'($random(seed));
      loadVmaFromAd(edpAd, vmaCtlPkg::SEC_AD);
      tick("decode");
    end
    // Diagnostic readback
    for (int d = 0; d < DIAG_RUNS; d++) begin
      diagSel = 3'(d);
      readVma = d < 8;
      tick("diag");
    end
    // Section-zero flags, VMA and previous section first, then the PC
    loadVmaFromAd('0, vmaCtlPkg::SEC_AD);
    loadPrevContext = 1;
    diagSel = vmaCtlPkg::DIAG_FLAGS;
    readVma = 1;
    tick("flagsVmaPrev");
    loadPc = 1;
    tick("flagsPc");
    $display("Errors: %0d model, %0d assertion", errors, dut0.chk0.failCount);
    if (errors == 0 && dut0.chk0.failCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/vmaTb_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module vmaAssertions (
  input logic clk, rstN,
  input logic loadPc, loadVmaHeld, datAoApr, loadPrevContext,
  input logic vmaLoad, vmaCount, readVma, ebusDriving,
  input kl10WordPkg::addrT vma, pc, held, adrBrk, edpAd,
  input kl10WordPkg::sectionT prevSec
);

  int failCount = 0;

  pcCopy: assert property (@(posedge clk) disable iff (!rstN)
    loadPc |=> pc == $past(vma)) else begin $error("pc"); failCount++; end
  heldCopy: assert property (@(posedge clk) disable iff (!rstN)
    loadVmaHeld |=> held == $past(vma)) else begin $error("held"); failCount++; end
  brkCopy: assert property (@(posedge clk) disable iff (!rstN)
    datAoApr |=> adrBrk == $past(edpAd)) else begin $error("adrBrk"); failCount++; end
  prevCopy: assert property (@(posedge clk) disable iff (!rstN)
    loadPrevContext |=> prevSec == $past(edpAd[22:18]))
    else begin $error("prevSec"); failCount++; end
  // Count keeps the section and wraps the offset
  countStep: assert property (@(posedge clk) disable iff (!rstN)
    vmaCount && !vmaLoad |=> vma == {$past(vma[22:18]), $past(vma[17:0]) + 18'd1})
    else begin $error("count"); failCount++; end
  ebusDrive: assert property (@(posedge clk) ebusDriving == readVma)
    else begin $error("ebusDriving"); failCount++; end

endmodule

bind vmaTop vmaAssertions chk0 (
  .clk(clk), .rstN(rstN), .loadPc(loadPc), .loadVmaHeld(loadVmaHeld),
  .datAoApr(datAoApr), .loadPrevContext(loadPrevContext), .vmaLoad(vmaLoad),
  .vmaCount(vmaCount), .readVma(readVma), .ebusDriving(ebusDriving), .vma(vma),
  .pc(pc), .held(held), .adrBrk(adrBrk), .edpAd(edpAd), .prevSec(prevSec)
);

`default_nettype wire

//--- verilog/kl10WordPkg.sv
`default_nettype none

package kl10WordPkg;

  // Widths of the things the VMA board handles
  localparam int WORD_W    = 36;
  localparam int SECTION_W = 5;
  localparam int OFFSET_W  = 18;
  localparam int ADDR_W    = SECTION_W + OFFSET_W;
  localparam int MAGIC_W   = 9;

  // EBUS data word
  typedef logic [WORD_W-1:0] wordT;

  // Virtual address, section in the upper bits and offset below
  typedef logic [ADDR_W-1:0] addrT;

  typedef logic [SECTION_W-1:0] sectionT;

  typedef logic [OFFSET_W-1:0] offsetT;

  // Microcode magic number field
  typedef logic [MAGIC_W-1:0] magicT;

  // Offsets below this address the fast accumulators
  localparam int unsigned AC_LIMIT = 16;

endpackage

`default_nettype wire

//--- verilog/vmaCounter.sv
`timescale 1ns/1ps
`default_nettype none

module vmaCounter (
  input  logic                    clk,
  input  logic                    rstN,
  input  kl10WordPkg::addrT       edpAd,
  input  kl10WordPkg::magicT      magic,
  input  logic                    condVmaMagic,
  input  logic                    vmaInc,
  input  logic                    vmaAdSel,
  input  logic                    vmaLoad,
  input  logic                    vmaCount,
  input  logic                    vmaxEn,
  input  vmaCtlPkg::sectionSelT   vmaxSel,
  input  kl10WordPkg::addrT       pc,
  input  kl10WordPkg::sectionT    prevSec,
  output kl10WordPkg::addrT       vma
);

  kl10WordPkg::offsetT  adBase;
  kl10WordPkg::offsetT  adSum;
  kl10WordPkg::offsetT  offsetIn;
  kl10WordPkg::offsetT  vmaOffset;
  kl10WordPkg::sectionT sectionIn;
  kl10WordPkg::sectionT vmaSec;

  assign vmaOffset = vma[kl10WordPkg::OFFSET_W-1:0];
  assign vmaSec    = vma[kl10WordPkg::OFFSET_W +: kl10WordPkg::SECTION_W];

  // VMA adder, PC or magic number plus the increment bit
  always_comb begin
    if (condVmaMagic) begin
      adBase = {{(kl10WordPkg::OFFSET_W - kl10WordPkg::MAGIC_W){1'b0}}, magic};
    end else begin
      adBase = pc[kl10WordPkg::OFFSET_W-1:0];
    end
    adSum = adBase + kl10WordPkg::offsetT'(vmaInc);
  end

  assign offsetIn = vmaAdSel ? edpAd[kl10WordPkg::OFFSET_W-1:0] : adSum;

  // Section source mux
  always_comb begin
    sectionIn = vmaSec;
    if (vmaxEn) begin
      case (vmaxSel)
        vmaCtlPkg::SEC_KEEP: sectionIn = vmaSec;
        vmaCtlPkg::SEC_PC:   sectionIn = pc[kl10WordPkg::OFFSET_W +: kl10WordPkg::SECTION_W];
        vmaCtlPkg::SEC_PREV: sectionIn = prevSec;
        vmaCtlPkg::SEC_AD:   sectionIn = edpAd[kl10WordPkg::OFFSET_W +: kl10WordPkg::SECTION_W];
        default:             sectionIn = vmaSec;
      endcase
    end
  end

  // Load wins over count
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      vma <= '0;
    end else if (vmaLoad) begin
      vma <= {sectionIn, offsetIn};
    end else if (vmaCount) begin
      // Count stays inside the section
      vma <= {vmaSec, vmaOffset + 1'b1};
    end
  end

endmodule

`default_nettype wire

//--- verilog/vmaCtlPkg.sv
`default_nettype none

package vmaCtlPkg;

  // Where the VMA section comes from on a load
  typedef logic [1:0] sectionSelT;

  localparam sectionSelT SEC_KEEP = 2'd0;
  localparam sectionSelT SEC_PC   = 2'd1;
  localparam sectionSelT SEC_PREV = 2'd2;
  localparam sectionSelT SEC_AD   = 2'd3;

  // Diagnostic readback select, codes above FLAGS read zero
  typedef logic [2:0] diagSelT;

  localparam diagSelT DIAG_VMA   = 3'd0;
  localparam diagSelT DIAG_PC    = 3'd1;
  localparam diagSelT DIAG_HELD  = 3'd2;
  localparam diagSelT DIAG_BRK   = 3'd3;
  localparam diagSelT DIAG_FLAGS = 3'd4;

endpackage

`default_nettype wire

//--- verilog/vmaHistory.sv
`timescale 1ns/1ps
`default_nettype none

module vmaHistory (
  input  logic                  clk,
  input  logic                  rstN,
  input  kl10WordPkg::addrT     vma,
  input  kl10WordPkg::addrT     edpAd,
  input  logic                  loadPc,
  input  logic                  loadVmaHeld,
  input  logic                  condSelVma,
  input  logic                  datAoApr,
  input  logic                  loadPrevContext,
  output kl10WordPkg::addrT     pc,
  output kl10WordPkg::addrT     held,
  output kl10WordPkg::addrT     adrBrk,
  output kl10WordPkg::addrT     heldOrPc,
  output kl10WordPkg::sectionT  prevSec
);

  // Saved PC
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= '0;
    end else if (loadPc) begin
      pc <= vma;
    end
  end

  // VMA held across a page fail
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      held <= '0;
    end else if (loadVmaHeld) begin
      held <= vma;
    end
  end

  // Address break, written by DATAO APR
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      adrBrk <= '0;
    end else if (datAoApr) begin
      adrBrk <= edpAd;
    end
  end

  // Previous context section
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      prevSec <= '0;
    end else if (loadPrevContext) begin
      prevSec <= edpAd[kl10WordPkg::OFFSET_W +: kl10WordPkg::SECTION_W];
    end
  end

  assign heldOrPc = condSelVma ? held : pc;

endmodule

`default_nettype wire

//--- verilog/vmaStatus.sv
`timescale 1ns/1ps
`default_nettype none

module vmaStatus (
  input  kl10WordPkg::addrT     vma,
  input  kl10WordPkg::addrT     pc,
  input  kl10WordPkg::addrT     held,
  input  kl10WordPkg::addrT     adrBrk,
  input  kl10WordPkg::sectionT  prevSec,
  input  logic                  vmaExtended,
  input  logic                  vmaFetch,
  input  logic                  pageRef,
  input  logic                  readOrWrite,
  input  logic                  readVma,
  input  vmaCtlPkg::diagSelT    diagSel,
  output logic                  acRef,
  output logic                  match,
  output logic                  localAcAddress,
  output logic                  ebusDriving,
  output kl10WordPkg::wordT     ebusData
);

  kl10WordPkg::offsetT  vmaOffset;
  kl10WordPkg::sectionT vmaSec;
  kl10WordPkg::sectionT pcSec;
  logic                 vmaSection0;
  logic                 pcSection0;
  logic                 prevSection0;
  logic                 acOffset;
  logic                 localRef;

  assign vmaOffset = vma[kl10WordPkg::OFFSET_W-1:0];
  assign vmaSec    = vma[kl10WordPkg::OFFSET_W +: kl10WordPkg::SECTION_W];
  assign pcSec     = pc[kl10WordPkg::OFFSET_W +: kl10WordPkg::SECTION_W];

  assign vmaSection0  = (vmaSec == '0);
  assign pcSection0   = (pcSec == '0);
  assign prevSection0 = (prevSec == '0);

  assign acOffset = (vmaOffset < kl10WordPkg::AC_LIMIT);

  // Unextended, instruction fetch or section 0 references stay local
  assign localRef = ~vmaExtended | vmaFetch | vmaSection0;

  assign acRef          = acOffset & localRef & pageRef & readOrWrite;
  assign localAcAddress = acOffset & localRef & ~vmaSection0;

  assign match = (vma == adrBrk);

  // Diagnostic readback, right-justified on the EBUS
  always_comb begin
    ebusData = '0;
    if (readVma) begin
      case (diagSel)
        vmaCtlPkg::DIAG_VMA:   ebusData = kl10WordPkg::wordT'(vma);
        vmaCtlPkg::DIAG_PC:    ebusData = kl10WordPkg::wordT'(pc);
        vmaCtlPkg::DIAG_HELD:  ebusData = kl10WordPkg::wordT'(held);
        vmaCtlPkg::DIAG_BRK:   ebusData = kl10WordPkg::wordT'(adrBrk);
        vmaCtlPkg::DIAG_FLAGS: begin
          ebusData = kl10WordPkg::wordT'({vmaSection0, pcSection0, prevSection0, prevSec});
        end
        default:               ebusData = '0;
      endcase
    end
  end

  assign ebusDriving = readVma;

endmodule

`default_nettype wire

//--- verilog/vmaTop.sv
`timescale 1ns/1ps
`default_nettype none

module vmaTop (
  input  logic                    clk,
  input  logic                    rstN,
  input  kl10WordPkg::addrT       edpAd,
  input  kl10WordPkg::magicT      magic,
  input  logic                    condVmaMagic,
  input  logic                    vmaInc,
  input  logic                    vmaAdSel,
  input  logic                    vmaLoad,
  input  logic                    vmaCount,
  input  logic                    vmaxEn,
  input  vmaCtlPkg::sectionSelT   vmaxSel,
  input  logic                    loadPc,
  input  logic                    loadVmaHeld,
  input  logic                    condSelVma,
  input  logic                    datAoApr,
  input  logic                    loadPrevContext,
  input  logic                    vmaExtended,
  input  logic                    vmaFetch,
  input  logic                    pageRef,
  input  logic                    readOrWrite,
  input  logic                    readVma,
  input  vmaCtlPkg::diagSelT      diagSel,
  output kl10WordPkg::addrT       vma,
  output kl10WordPkg::addrT       pc,
  output kl10WordPkg::addrT       heldOrPc,
  output logic                    acRef,
  output logic                    match,
  output logic                    localAcAddress,
  output kl10WordPkg::wordT       ebusData,
  output logic                    ebusDriving
);

  kl10WordPkg::addrT    held;
  kl10WordPkg::addrT    adrBrk;
  kl10WordPkg::sectionT prevSec;

  vmaCounter counter0 (
    .clk          (clk),
    .rstN         (rstN),
    .edpAd        (edpAd),
    .magic        (magic),
    .condVmaMagic (condVmaMagic),
    .vmaInc       (vmaInc),
    .vmaAdSel     (vmaAdSel),
    .vmaLoad      (vmaLoad),
    .vmaCount     (vmaCount),
    .vmaxEn       (vmaxEn),
    .vmaxSel      (vmaxSel),
    .pc           (pc),
    .prevSec      (prevSec),
    .vma          (vma)
  );

  vmaHistory history0 (
    .clk             (clk),
    .rstN            (rstN),
    .vma             (vma),
    .edpAd           (edpAd),
    .loadPc          (loadPc),
    .loadVmaHeld     (loadVmaHeld),
    .condSelVma      (condSelVma),
    .datAoApr        (datAoApr),
    .loadPrevContext (loadPrevContext),
    .pc              (pc),
    .held            (held),
    .adrBrk          (adrBrk),
    .heldOrPc        (heldOrPc),
    .prevSec         (prevSec)
  );

  vmaStatus status0 (
    .vma            (vma),
    .pc             (pc),
    .held           (held),
    .adrBrk         (adrBrk),
    .prevSec        (prevSec),
    .vmaExtended    (vmaExtended),
    .vmaFetch       (vmaFetch),
    .pageRef        (pageRef),
    .readOrWrite    (readOrWrite),
    .readVma        (readVma),
    .diagSel        (diagSel),
    .acRef          (acRef),
    .match          (match),
    .localAcAddress (localAcAddress),
    .ebusDriving    (ebusDriving),
    .ebusData       (ebusData)
  );

endmodule

`default_nettype wire
